// ==== verilog/lcdPkg.sv ====
package lcdPkg;

  typedef enum logic [2:0] {
    opInit,
    opDisplayOn,
    opDisplayOff,
    opClear,
    opFill
  } lcdOp;

  typedef enum logic [2:0] {
    sendCmd,     // dcx low
    sendParam,   // constant byte, dcx high
    sendWindow,  // start hi/lo, end hi/lo
    sendPixels,
    waitCycles,  // bus released
    endScript
  } stepKind;

  // panel opcodes
  localparam logic [7:0] cmdSwReset     = 8'h01;
  localparam logic [7:0] cmdSleepIn     = 8'h10;
  localparam logic [7:0] cmdSleepOut    = 8'h11;
  localparam logic [7:0] cmdDisplayOff  = 8'h28;
  localparam logic [7:0] cmdDisplayOn   = 8'h29;
  localparam logic [7:0] cmdColumnAddr  = 8'h2A;
  localparam logic [7:0] cmdPageAddr    = 8'h2B;
  localparam logic [7:0] cmdMemWrite    = 8'h2C;
  localparam logic [7:0] cmdOrientation = 8'h36;
  localparam logic [7:0] cmdPixelFormat = 8'h3A;

  localparam logic [7:0] paramPixelFormat = 8'h55;  // 16 bit rgb565
  localparam logic [7:0] paramOrientation = 8'hB8;

  // step values for window and wait steps
  localparam logic [7:0] windowX = 8'd0;
  localparam logic [7:0] windowY = 8'd1;

  localparam logic [7:0] waitSelReset   = 8'd0;
  localparam logic [7:0] waitSelSleep   = 8'd1;
  localparam logic [7:0] waitSelDisplay = 8'd2;

  localparam int screenWidth  = 320;
  localparam int screenHeight = 240;

  // clock cycles, short for simulation
  localparam logic [23:0] resetWaitCycles   = 24'd400;
  localparam logic [23:0] sleepWaitCycles   = 24'd800;
  localparam logic [23:0] displayWaitCycles = 24'd200;

  localparam int maxSteps        = 16;
  localparam int stepIndexWidth  = $clog2(maxSteps);
  localparam int pixelCountWidth = 17;  // up to 76800 pixels

endpackage

// ==== verilog/lcdScriptRom.sv ====
`timescale 1ns/1ns

module lcdScriptRom (
  input  lcdPkg::lcdOp scriptOp,
  input  logic [lcdPkg::stepIndexWidth-1:0] stepIndex,
  output lcdPkg::stepKind stepKind,
  output logic [7:0] stepValue
);
  import lcdPkg::*;

  logic [10:0] entry;  // kind and value

  always_comb begin
    entry = {endScript, 8'h00};
    case (scriptOp)
      opInit: begin
        case (stepIndex)
          4'd0: entry = {sendCmd, cmdSwReset};
          4'd1: entry = {waitCycles, waitSelReset};
          4'd2: entry = {sendCmd, cmdSleepOut};
          4'd3: entry = {waitCycles, waitSelSleep};
          4'd4: entry = {sendCmd, cmdPixelFormat};
          4'd5: entry = {sendParam, paramPixelFormat};
          4'd6: entry = {sendCmd, cmdOrientation};
          4'd7: entry = {sendParam, paramOrientation};
          4'd8: entry = {sendCmd, cmdDisplayOn};
          default: entry = {endScript, 8'h00};
        endcase
      end

      opDisplayOn: begin
        case (stepIndex)
          4'd0: entry = {sendCmd, cmdSleepOut};
          4'd1: entry = {waitCycles, waitSelSleep};
          4'd2: entry = {sendCmd, cmdDisplayOn};
          default: entry = {endScript, 8'h00};
        endcase
      end

      opDisplayOff: begin
        case (stepIndex)
          4'd0: entry = {sendCmd, cmdDisplayOff};
          4'd1: entry = {waitCycles, waitSelDisplay};
          4'd2: entry = {sendCmd, cmdSleepIn};
          4'd3: entry = {waitCycles, waitSelSleep};
          default: entry = {endScript, 8'h00};
        endcase
      end

      // clear only differs in the latched window and colour
      opClear, opFill: begin
        case (stepIndex)
          4'd0: entry = {sendCmd, cmdColumnAddr};
          4'd1: entry = {sendWindow, windowX};
          4'd2: entry = {sendCmd, cmdPageAddr};
          4'd3: entry = {sendWindow, windowY};
          4'd4: entry = {sendCmd, cmdMemWrite};
          4'd5: entry = {sendPixels, 8'h00};
          default: entry = {endScript, 8'h00};
        endcase
      end

      default: entry = {endScript, 8'h00};
    endcase
  end

  assign stepKind = lcdPkg::stepKind'(entry[10:8]);
  assign stepValue = entry[7:0];

endmodule

// ==== verilog/lcdSequencer.sv ====
`timescale 1ns/1ns

module lcdSequencer (
  input  logic clk,
  input  logic rst,
  input  logic req,
  input  lcdPkg::lcdOp op,
  input  logic [31:0] xWindow,
  input  logic [31:0] yWindow,
  input  logic [15:0] color,
  output logic ack,
  output lcdPkg::lcdOp scriptOp,
  output logic [lcdPkg::stepIndexWidth-1:0] stepIndex,
  input  lcdPkg::stepKind stepKind,
  input  logic [7:0] stepValue,
  output logic byteValid,
  output logic [7:0] byteData,
  output logic byteIsData,
  output logic byteLast,
  input  logic byteReady
);
  import lcdPkg::*;

  typedef enum logic [2:0] {sIdle, sLoad, sRun, sDrain, sWait} seqState;

  seqState state;
  lcdOp opReg;
  logic [31:0] xReg;
  logic [31:0] yReg;
  logic [15:0] colorReg;
  lcdPkg::stepKind curKind;  // rom output is always the step after this one
  logic [7:0] curValue;
  logic [1:0] byteCount;
  logic hiByte;
  logic [pixelCountWidth-1:0] pixelsLeft;
  logic [pixelCountWidth-1:0] xSpan;
  logic [pixelCountWidth-1:0] ySpan;
  logic [pixelCountWidth-1:0] area;
  logic [23:0] waitTimer;
  logic [23:0] waitLength;
  logic [31:0] windowWord;
  logic accept;
  logic moved;
  logic stepDone;
  logic loadStep;

  assign scriptOp = opReg;
  assign accept = (state == sIdle) && !ack && req;

  assign xSpan = xReg[15:0] - xReg[31:16] + 1'b1;
  assign ySpan = yReg[15:0] - yReg[31:16] + 1'b1;
  assign area = xSpan * ySpan;

  always_comb begin
    case (stepValue)
      waitSelSleep:   waitLength = sleepWaitCycles;
      waitSelDisplay: waitLength = displayWaitCycles;
      default:        waitLength = resetWaitCycles;
    endcase
  end

  assign windowWord = (curValue == windowY) ? yReg : xReg;

  always_comb begin
    case (curKind)
      sendWindow: byteData = windowWord[31 - 8 * byteCount -: 8];  // msb first
      sendPixels: byteData = hiByte ? colorReg[15:8] : colorReg[7:0];
      default:    byteData = curValue;
    endcase
  end

  always_comb begin
    case (curKind)
      sendWindow: stepDone = (byteCount == 2'd3);
      sendPixels: stepDone = !hiByte && (pixelsLeft == 1);
      default:    stepDone = 1'b1;
    endcase
  end

  assign byteIsData = (curKind != sendCmd);
  assign byteValid = (state == sRun);
  assign moved = byteValid && byteReady;
  // writer releases csx after this byte
  assign byteLast = stepDone && (stepKind == waitCycles || stepKind == endScript);

  assign loadStep = (state == sLoad) ||
                    (moved && stepDone && !byteLast) ||
                    (state == sDrain && byteReady) ||  // writer back in release
                    (state == sWait && waitTimer == 0);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= sIdle;
      ack <= 1'b0;
      stepIndex <= '0;
      curKind <= endScript;
      byteCount <= '0;
      hiByte <= 1'b1;
      pixelsLeft <= '0;
      waitTimer <= '0;
    end else begin
      if (loadStep) begin
        stepIndex <= stepIndex + 1'b1;
        curKind <= stepKind;
        byteCount <= '0;
        hiByte <= 1'b1;
        pixelsLeft <= area;
        waitTimer <= waitLength - 1'b1;
      end else if (moved) begin
        byteCount <= byteCount + 1'b1;
        hiByte <= !hiByte;
        if (!hiByte) pixelsLeft <= pixelsLeft - 1'b1;
      end else if (state == sWait) begin
        waitTimer <= waitTimer - 1'b1;
      end

      if (state == sIdle) begin
        if (ack && !req) ack <= 1'b0;  // host finished the handshake
        if (accept) begin
          stepIndex <= '0;
          state <= sLoad;
        end
      end else if (loadStep) begin
        case (stepKind)
          waitCycles: state <= sWait;
          endScript: begin
            state <= sIdle;
            ack <= 1'b1;
          end
          default: state <= sRun;
        endcase
      end else if (moved && byteLast) begin
        state <= sDrain;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opReg <= op;
      if (op == opClear) begin
        xReg <= {16'd0, 16'(screenWidth - 1)};
        yReg <= {16'd0, 16'(screenHeight - 1)};
        colorReg <= '0;  // black
      end else begin
        xReg <= xWindow;
        yReg <= yWindow;
        colorReg <= color;
      end
    end
    if (loadStep) curValue <= stepValue;
  end

endmodule

// ==== verilog/lcdBusWriter.sv ====
`timescale 1ns/1ns

module lcdBusWriter (
  input  logic clk,
  input  logic rst,
  input  logic byteValid,
  input  logic [7:0] byteData,
  input  logic byteIsData,
  input  logic byteLast,
  output logic byteReady,
  output logic csx,
  output logic wrx,
  output logic dcx,
  output logic [7:0] data
);

  typedef enum logic [2:0] {wIdle, wSelect, wStrobeLow, wStrobeHigh, wRelease} writerState;

  writerState state;
  writerState nextState;
  logic nextCsx;
  logic nextWrx;
  logic nextDcx;
  logic [7:0] nextData;
  logic lastReg;
  logic nextLast;
  logic take;

  assign byteReady = (state == wIdle) || (state == wRelease) ||
                     (state == wStrobeHigh && !lastReg);
  assign take = byteValid && byteReady;

  always_comb begin
    nextState = state;
    nextCsx = csx;
    nextWrx = wrx;
    nextDcx = dcx;
    nextData = data;
    nextLast = lastReg;
    case (state)
      wIdle, wRelease: begin
        if (take) begin
          nextCsx = 1'b0;  // data and dcx set up with csx
          nextData = byteData;
          nextDcx = byteIsData;
          nextLast = byteLast;
          nextState = wSelect;
        end else if (state == wRelease) begin
          nextData = 8'h00;
          nextDcx = 1'b1;
          nextState = wIdle;
        end
      end
      wSelect: begin
        nextWrx = 1'b0;
        nextState = wStrobeLow;
      end
      wStrobeLow: begin
        nextWrx = 1'b1;  // panel latches here
        nextState = wStrobeHigh;
      end
      wStrobeHigh: begin
        if (lastReg) begin
          nextCsx = 1'b1;
          nextState = wRelease;
        end else if (take) begin
          nextWrx = 1'b0;  // back to back byte
          nextData = byteData;
          nextDcx = byteIsData;
          nextLast = byteLast;
          nextState = wStrobeLow;
        end
      end
      default: nextState = wIdle;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= wIdle;
      csx <= 1'b1;
      wrx <= 1'b1;
      dcx <= 1'b1;
      data <= 8'h00;
      lastReg <= 1'b0;
    end else begin
      state <= nextState;
      csx <= nextCsx;
      wrx <= nextWrx;
      dcx <= nextDcx;
      data <= nextData;
      lastReg <= nextLast;
    end
  end

endmodule

// ==== verilog/lcdController.sv ====
`timescale 1ns/1ns

module lcdController (
  input  logic clk,
  input  logic rst,
  input  logic req,
  input  lcdPkg::lcdOp op,
  input  logic [31:0] xWindow,
  input  logic [31:0] yWindow,
  input  logic [15:0] color,
  output logic ack,
  output logic csx,
  output logic wrx,
  output logic dcx,
  output logic [7:0] data
);
  import lcdPkg::*;

  lcdOp scriptOp;
  logic [stepIndexWidth-1:0] stepIndex;
  lcdPkg::stepKind stepKind;
  logic [7:0] stepValue;
  logic byteValid;
  logic [7:0] byteData;
  logic byteIsData;
  logic byteLast;
  logic byteReady;

  lcdSequencer sequencer (
    .clk(clk),
    .rst(rst),
    .req(req),
    .op(op),
    .xWindow(xWindow),
    .yWindow(yWindow),
    .color(color),
    .ack(ack),
    .scriptOp(scriptOp),
    .stepIndex(stepIndex),
    .stepKind(stepKind),
    .stepValue(stepValue),
    .byteValid(byteValid),
    .byteData(byteData),
    .byteIsData(byteIsData),
    .byteLast(byteLast),
    .byteReady(byteReady)
  );

  lcdScriptRom scriptRom (
    .scriptOp(scriptOp),
    .stepIndex(stepIndex),
    .stepKind(stepKind),
    .stepValue(stepValue)
  );

  lcdBusWriter busWriter (
    .clk(clk),
    .rst(rst),
    .byteValid(byteValid),
    .byteData(byteData),
    .byteIsData(byteIsData),
    .byteLast(byteLast),
    .byteReady(byteReady),
    .csx(csx),
    .wrx(wrx),
    .dcx(dcx),
    .data(data)
  );

endmodule

// ==== test/tbClock.sv ====
`timescale 1ns/1ns

module tbClock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// ==== test/lcdController_assertions.sv ====
`timescale 1ns/1ns

module lcdController_assertions (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic csx,
  input logic wrx,
  input logic dcx,
  input logic [7:0] data
);

  int failCount = 0;
  logic seenReq;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      seenReq <= 1'b0;
    end else if (req) begin
      seenReq <= 1'b1;
    end
  end

  idleBeforeReq: assert property (@(posedge clk)
      !seenReq |-> csx && wrx && dcx && data == 8'h00 && !ack)
    else begin
      $error("bus or ack not idle before the first request");
      failCount++;
    end

  ackOnlyWithReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else begin
      $error("ack rose without a pending request");
      failCount++;
    end

  ackHeld: assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
    else begin
      $error("ack dropped while req was still high");
      failCount++;
    end

  ackReleased: assert property (@(posedge clk) disable iff (rst) ack && !req |=> !ack)
    else begin
      $error("ack did not fall the cycle after req fell");
      failCount++;
    end

  strobeSelected: assert property (@(posedge clk) disable iff (rst) !wrx |-> !csx && !ack)
    else begin
      $error("wrx low with csx high or ack high");
      failCount++;
    end

  strobeStable: assert property (@(posedge clk) disable iff (rst)
      !wrx |=> $stable(data) && $stable(dcx))
    else begin
      $error("data or dcx changed while wrx was low");
      failCount++;
    end

endmodule

bind lcdController lcdController_assertions protocolChecks (
  .clk(clk), .rst(rst), .req(req), .ack(ack),
  .csx(csx), .wrx(wrx), .dcx(dcx), .data(data)
);

// ==== test/lcdControllerTb.sv ====
`timescale 1ns/1ns

module lcdControllerTb;
  import lcdPkg::*;

  localparam int fills = 5;

  logic clk;
  logic rst;
  logic req;
  lcdOp op;
  logic [31:0] xWindow;
  logic [31:0] yWindow;
  logic [15:0] color;
  logic ack;
  logic csx;
  logic wrx;
  logic dcx;
  logic [7:0] data;

  integer seed = 32'h03d8_9758;
  int errors = 0;
  int errorsAtStart = 0;
  int passed = 0;
  int failed = 0;
  int csxRun = 0;
  int maxRun = 0;
  int gapRuns[$];  // longest csx high stretch before each latched byte
  logic [8:0] expected[$];  // dcx and data
  logic wrxLast = 1'b1;
  longint budget = 0;

  tbClock clockGen (.clk(clk), .rst(rst));

  lcdController dut (
    .clk(clk), .rst(rst), .req(req), .op(op), .xWindow(xWindow), .yWindow(yWindow),
    .color(color), .ack(ack), .csx(csx), .wrx(wrx), .dcx(dcx), .data(data)
  );

  // panel side, latch on the wrx rise
  always @(negedge clk) begin : busMonitor
    logic [8:0] want;
    csxRun = csx ? csxRun + 1 : 0;
    if (csxRun > maxRun) maxRun = csxRun;
    if (!rst && wrx && !wrxLast) begin
      if (gapRuns.size() < 8) gapRuns.push_back(maxRun);
      maxRun = 0;
      assert (expected.size() != 0) else begin
        $display("Unexpected byte %h with dcx %b on the bus at %0t", data, dcx, $time);
        errors++;
      end
      if (expected.size() != 0) begin
        want = expected.pop_front();
        assert ({dcx, data} == want) else begin
          if (data != want[7:0])
            $display("Mismatch at %0t ns: data is %h, expected %h", $time, data, want[7:0]);
          if (dcx != want[8])
            $display("Mismatch at %0t ns: dcx is %b, expected %b", $time, dcx, want[8]);
          errors++;
        end
      end
    end
    wrxLast = wrx;
  end

  function automatic int totalErrors();
    return errors + dut.protocolChecks.failCount;
  endfunction

  task automatic pushByte(input logic isData, input logic [7:0] value);
    expected.push_back({isData, value});
  endtask

  task automatic pushWindow(input logic [31:0] window);
    for (int i = 3; i >= 0; i--) pushByte(1'b1, window[8 * i +: 8]);  // start hi first
  endtask

  task automatic pushFill(input logic [31:0] xw, input logic [31:0] yw, input logic [15:0] rgb,
                          input int pixels);
    pushByte(1'b0, 8'h2A);
    pushWindow(xw);
    pushByte(1'b0, 8'h2B);
    pushWindow(yw);
    pushByte(1'b0, 8'h2C);
    repeat (pixels) begin
      pushByte(1'b1, rgb[15:8]);
      pushByte(1'b1, rgb[7:0]);
    end
  endtask

  task automatic runOp(input lcdOp which, input logic [31:0] xw, input logic [31:0] yw,
                       input logic [15:0] rgb, input int hold);
    @(posedge clk);
    #1;
    errorsAtStart = totalErrors();
    gapRuns.delete();
    maxRun = 0;
    op = which;
    xWindow = xw;
    yWindow = yw;
    color = rgb;
    req = 1'b1;
    do @(posedge clk); while (!ack);
    repeat (hold) @(posedge clk);  // back pressure
    #1 req = 1'b0;
    do @(posedge clk); while (ack);
  endtask

  task automatic checkRun(input int run, input int cycles, input string what);
    assert (run >= cycles) else begin
      $display("csx was high for only %0d cycles around the %s wait", run, what);
      errors++;
    end
  endtask

  task automatic finishTest(input string name);
    assert (expected.size() == 0) else begin
      $display("Test %s: %0d expected bytes never reached the bus", name, expected.size());
      errors++;
    end
    expected.delete();
    if (totalErrors() == errorsAtStart) begin
      passed++;
      $display("Test %s passed", name);
    end else begin
      failed++;
      $display("Test %s failed", name);
    end
  endtask

  initial begin : watchdog
    wait (budget > 0);
    #(budget);
    $display("Timeout: the run did not end within %0d ns", budget);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [15:0] xs;
    logic [15:0] ys;
    logic [15:0] w;
    logic [15:0] h;
    logic [31:0] fillX[fills];
    logic [31:0] fillY[fills];
    logic [15:0] fillColor[fills];
    int fillPixels[fills];
    longint cycles;
    req = 1'b0;
    op = opInit;
    xWindow = '0;
    yWindow = '0;
    color = '0;
    cycles = 16 + 14 + resetWaitCycles + sleepWaitCycles;
    cycles += 8 + displayWaitCycles + 2 * sleepWaitCycles + 50;
    cycles += 2 * (11 + 2 * screenWidth * screenHeight) + 16 * (fills + 4);
    for (int i = 0; i < fills; i++) begin
      xs = 16'({$random(seed)} % 313);  // window of up to 8 still fits
      w = 16'({$random(seed)} % 8 + 1);
      ys = 16'({$random(seed)} % 233);
      h = 16'({$random(seed)} % 8 + 1);
      fillX[i] = {xs, xs + w - 16'd1};
      fillY[i] = {ys, ys + h - 16'd1};
      fillColor[i] = 16'($random(seed));
      fillPixels[i] = w * h;
      cycles += 2 * (11 + 2 * w * h);
    end
    budget = cycles * 2 * 8;  // twice the expected run, in ns

    while (rst) @(posedge clk);
    repeat (4) @(posedge clk);
    finishTest("reset");

    pushByte(1'b0, 8'h01);
    pushByte(1'b0, 8'h11);
    pushByte(1'b0, 8'h3A);
    pushByte(1'b1, 8'h55);
    pushByte(1'b0, 8'h36);
    pushByte(1'b1, 8'hB8);
    pushByte(1'b0, 8'h29);
    runOp(opInit, '0, '0, '0, 0);
    checkRun(gapRuns[1], resetWaitCycles, "reset");
    checkRun(gapRuns[2], sleepWaitCycles, "sleep");
    finishTest("init");

    pushByte(1'b0, 8'h28);
    pushByte(1'b0, 8'h10);
    runOp(opDisplayOff, '0, '0, '0, 0);
    checkRun(gapRuns[1], displayWaitCycles, "display");
    checkRun(maxRun, sleepWaitCycles, "sleep");  // script ends on a wait
    finishTest("display off");

    pushByte(1'b0, 8'h11);
    pushByte(1'b0, 8'h29);
    runOp(opDisplayOn, '0, '0, '0, 50);
    checkRun(gapRuns[1], sleepWaitCycles, "sleep");
    finishTest("display on");

    for (int i = 0; i < fills; i++) begin
      pushFill(fillX[i], fillY[i], fillColor[i], fillPixels[i]);
      runOp(opFill, fillX[i], fillY[i], fillColor[i], 0);
      finishTest($sformatf("fill %0d", i));
    end

    // host window and colour must be ignored
    pushFill(32'h0000_013F, 32'h0000_00EF, 16'h0000, 320 * 240);
    runOp(opClear, fillX[0], fillY[0], 16'hFFFF, 0);
    finishTest("clear");

    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0 && totalErrors() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== lcdController.f ====
verilog/lcdPkg.sv
verilog/lcdScriptRom.sv
verilog/lcdSequencer.sv
verilog/lcdBusWriter.sv
verilog/lcdController.sv
test/tbClock.sv
test/lcdController_assertions.sv
test/lcdControllerTb.sv
